/* hdl/mm_pkg.sv */
// Q8.8 element format and row word layout shared by the whole accelerator
// Element k of a row sits at bits [16*k+15:16*k], so element 0 is the low half-word
package mm_pkg;

    localparam int ELEM_WIDTH = 16;                        // One Q8.8 element
    localparam int FRAC_WIDTH = 8;                         // Fraction bits
    localparam int INNER_DIM  = 4;                         // Elements per row
    localparam int ROW_WIDTH  = ELEM_WIDTH * INNER_DIM;    // One stream beat
    localparam int PROD_WIDTH = 2 * ELEM_WIDTH;            // Full signed product
    localparam int ACC_WIDTH  = PROD_WIDTH + $clog2(INNER_DIM); // Sum of all products, 34 bits

    typedef logic signed [ELEM_WIDTH-1:0] elem_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    // Same 64 bits, stored flat and taken apart per element by the datapath
    typedef union packed {
        logic [ROW_WIDTH-1:0]    flat;   // FIFO and buffer view
        elem_t [INNER_DIM-1:0]   elems;  // Dot-product view
    } row_word_t;

    // Longer of the two matrices, sets the load phase length
    function automatic int max_rows(input int a_rows, input int b_rows);
        return (a_rows > b_rows) ? a_rows : b_rows;
    endfunction

endpackage

/* hdl/fifo_rd_if.sv */
// Read side of a stream_fifo, first-word fall-through
// The reader must not pulse rd_en while empty is high
interface fifo_rd_if #(
    parameter int DEPTH = 16                       // Must match the FIFO instance
) (
    input logic aclk_i,
    input logic aresetn_i
);
    logic                         rd_en;           // Pop the head entry
    mm_pkg::row_word_t            rd_data;         // Head entry, zero padded if narrower
    logic [$clog2(DEPTH+1)-1:0]   count;           // Occupancy
    logic                         empty;

    modport fifo_side (
        input  aclk_i, aresetn_i, rd_en,
        output rd_data, count, empty
    );

    modport reader_side (
        input  aclk_i, aresetn_i, rd_data, count, empty,
        output rd_en
    );

endinterface

/* hdl/stream_fifo.sv */
// Synchronous FIFO, AXI-Stream write side and strobe read side, any DEPTH >= 2
// DATA_WIDTH is limited to the row word width; narrower entries are zero padded on read
module stream_fifo #(
    parameter int DATA_WIDTH = 64,
    parameter int DEPTH      = 16
) (
    input  logic                  aclk_i,
    input  logic                  aresetn_i,
    input  logic [DATA_WIDTH-1:0] s_tdata_i,
    input  logic                  s_tvalid_i,
    output logic                  s_tready_o,
    fifo_rd_if.fifo_side          rd
);
    localparam int PTR_WIDTH = $clog2(DEPTH);
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];                  // Payload storage
    logic [PTR_WIDTH-1:0]  wr_ptr_reg;
    logic [PTR_WIDTH-1:0]  rd_ptr_reg;
    logic [CNT_WIDTH-1:0]  count_reg;
    logic                  push;
    logic                  pop;

    assign s_tready_o = (count_reg != CNT_WIDTH'(DEPTH)); // Not full
    assign push       = s_tvalid_i && s_tready_o;        // AXI-Stream beat accepted
    assign pop        = rd.rd_en && !rd.empty;

    assign rd.empty        = (count_reg == '0);
    assign rd.count        = count_reg;
    assign rd.rd_data.flat = mm_pkg::ROW_WIDTH'(mem[rd_ptr_reg]); // Head shows without a read

    always_ff @(posedge aclk_i)
    begin
        if (push)
        begin
            mem[wr_ptr_reg] <= s_tdata_i;
        end
    end

    always_ff @(posedge aclk_i)
    begin
        if (!aresetn_i)
        begin
            wr_ptr_reg <= '0;
            rd_ptr_reg <= '0;
            count_reg  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr_reg <= (wr_ptr_reg == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr_reg + 1'b1;
            end
            if (pop)
            begin
                rd_ptr_reg <= (rd_ptr_reg == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr_reg + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop)
            begin
                count_reg <= count_reg + 1'b1;
            end
            else if (pop && !push)
            begin
                count_reg <= count_reg - 1'b1;
            end
        end
    end

endmodule

/* hdl/operand_buffer.sv */
// Row memory for one operand matrix, read data valid one cycle after the address
module operand_buffer #(
    parameter  int ROWS = 8,
    localparam int AW   = $clog2(ROWS)               // ROWS >= 2
) (
    input  logic              aclk_i,
    input  logic              wr_en_i,
    input  logic [AW-1:0]     wr_addr_i,
    input  mm_pkg::row_word_t wr_row_i,
    input  logic [AW-1:0]     rd_addr_i,
    output mm_pkg::row_word_t rd_row_o
);
    logic [mm_pkg::ROW_WIDTH-1:0] mem [ROWS];        // Rows kept as flat words

    always_ff @(posedge aclk_i)
    begin
        if (wr_en_i)
        begin
            mem[wr_addr_i] <= wr_row_i.flat;         // Load phase write
        end
    end

    always_ff @(posedge aclk_i)
    begin
        rd_row_o.flat <= mem[rd_addr_i];             // Registered read
    end

endmodule

/* hdl/dot_product_unit.sv */
// Two-stage Q8.8 dot product, result = sat16((sum of a*w) >>> 8), truncating toward -inf
// One new pair per cycle, two items in flight
module dot_product_unit (
    input  logic              aclk_i,
    input  logic              aresetn_i,
    input  logic              valid_i,
    input  logic              last_i,
    input  mm_pkg::row_word_t a_row_i,
    input  mm_pkg::row_word_t w_row_i,
    output mm_pkg::elem_t     result_o,
    output logic              valid_o,
    output logic              last_o
);
    localparam mm_pkg::acc_t SAT_MAX = 2 ** (mm_pkg::ELEM_WIDTH - 1) - 1;  // 32767
    localparam mm_pkg::acc_t SAT_MIN = -(2 ** (mm_pkg::ELEM_WIDTH - 1));   // -32768

    logic signed [mm_pkg::PROD_WIDTH-1:0] prod_reg [mm_pkg::INNER_DIM];    // Stage 1 products
    logic          valid_s1_reg;
    logic          last_s1_reg;
    mm_pkg::acc_t  sum;
    mm_pkg::acc_t  sum_shift;
    mm_pkg::elem_t sat;

    // Stage 1 multiplies, signed elements from the union view
    always_ff @(posedge aclk_i)
    begin
        for (int k = 0; k < mm_pkg::INNER_DIM; k++)
        begin
            prod_reg[k] <= a_row_i.elems[k] * w_row_i.elems[k];
        end
    end

    always_comb
    begin
        sum = '0;
        for (int k = 0; k < mm_pkg::INNER_DIM; k++)
        begin
            sum = sum + prod_reg[k];                  // Sign extended to 34 bits
        end
        sum_shift = sum >>> mm_pkg::FRAC_WIDTH;       // Back to Q8.8 scale
        if (sum_shift > SAT_MAX)
        begin
            sat = mm_pkg::elem_t'(SAT_MAX);
        end
        else if (sum_shift < SAT_MIN)
        begin
            sat = mm_pkg::elem_t'(SAT_MIN);
        end
        else
        begin
            sat = sum_shift[mm_pkg::ELEM_WIDTH-1:0];
        end
    end

    // Stage 2 result register
    always_ff @(posedge aclk_i)
    begin
        result_o <= sat;
    end

    always_ff @(posedge aclk_i)
    begin
        if (!aresetn_i)
        begin
            valid_s1_reg <= 1'b0;
            last_s1_reg  <= 1'b0;
            valid_o      <= 1'b0;
            last_o       <= 1'b0;
        end
        else
        begin
            valid_s1_reg <= valid_i;                  // Strobes follow the data
            last_s1_reg  <= last_i;
            valid_o      <= valid_s1_reg;
            last_o       <= last_s1_reg;
        end
    end

endmodule

/* hdl/mm_controller.sv */
// Job sequencer, waits for full A and W in the FIFOs, loads, issues C in row-major order
// Issue never stalls, so the output FIFO must hold a whole job; I_ROWS, W_ROWS >= 2
module mm_controller #(
    parameter  int I_ROWS = 8,
    parameter  int W_ROWS = 6,
    localparam int LD_AW  = $clog2(mm_pkg::max_rows(I_ROWS, W_ROWS)),
    localparam int A_AW   = $clog2(I_ROWS),
    localparam int W_AW   = $clog2(W_ROWS)
) (
    input  logic              aclk_i,
    input  logic              aresetn_i,
    fifo_rd_if.reader_side    a_rd,
    fifo_rd_if.reader_side    w_rd,
    input  logic              out_empty_i,
    output logic              a_wr_en_o,
    output logic              w_wr_en_o,
    output logic [LD_AW-1:0]  wr_addr_o,
    output logic [A_AW-1:0]   a_rd_addr_o,
    output logic [W_AW-1:0]   w_rd_addr_o,
    output logic              issue_valid_o,
    output logic              issue_last_o,
    input  logic              res_last_i
);
    localparam int LD_ROWS = mm_pkg::max_rows(I_ROWS, W_ROWS);

    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] LOAD    = 2'd1;
    localparam logic [1:0] COMPUTE = 2'd2;
    localparam logic [1:0] DRAIN   = 2'd3;

    logic [1:0]       state_reg, state_next;
    logic [LD_AW-1:0] ld_cnt_reg, ld_cnt_next;        // Load row, shared by both buffers
    logic [A_AW-1:0]  row_reg, row_next;              // Row of C
    logic [W_AW-1:0]  col_reg, col_next;              // Column of C
    logic             seen_last_reg, seen_last_next;  // Final result has left the pipeline
    logic             jobs_ready;
    logic             last_ld;
    logic             last_elem;

    assign jobs_ready = (a_rd.count >= I_ROWS) && (w_rd.count >= W_ROWS); // Whole job buffered
    assign last_ld    = (ld_cnt_reg == LD_AW'(LD_ROWS - 1));
    assign last_elem  = (row_reg == A_AW'(I_ROWS - 1)) && (col_reg == W_AW'(W_ROWS - 1));

    // Shorter matrix stops writing once its rows are in
    assign a_wr_en_o  = (state_reg == LOAD) && (ld_cnt_reg < I_ROWS);
    assign w_wr_en_o  = (state_reg == LOAD) && (ld_cnt_reg < W_ROWS);
    assign a_rd.rd_en = a_wr_en_o;                    // FIFO head is the write data
    assign w_rd.rd_en = w_wr_en_o;
    assign wr_addr_o  = ld_cnt_reg;

    assign a_rd_addr_o = row_reg;
    assign w_rd_addr_o = col_reg;

    always_comb
    begin
        state_next     = state_reg;
        ld_cnt_next    = ld_cnt_reg;
        row_next       = row_reg;
        col_next       = col_reg;
        seen_last_next = seen_last_reg;
        case (state_reg)
            IDLE:
            begin
                if (jobs_ready)
                begin
                    state_next = LOAD;
                end
            end
            LOAD:
            begin
                ld_cnt_next = last_ld ? '0 : ld_cnt_reg + 1'b1;
                if (last_ld)
                begin
                    state_next = COMPUTE;
                end
            end
            COMPUTE:                                  // One dot product per cycle
            begin
                if (col_reg == W_AW'(W_ROWS - 1))
                begin
                    col_next = '0;
                    row_next = (row_reg == A_AW'(I_ROWS - 1)) ? '0 : row_reg + 1'b1;
                end
                else
                begin
                    col_next = col_reg + 1'b1;
                end
                if (last_elem)
                begin
                    state_next = DRAIN;
                end
            end
            default:                                  // DRAIN
            begin
                if (res_last_i)
                begin
                    seen_last_next = 1'b1;
                end
                // Last result is in the output FIFO one cycle after res_last_i
                if (seen_last_reg && out_empty_i)
                begin
                    seen_last_next = 1'b0;
                    state_next     = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge aclk_i)
    begin
        if (!aresetn_i)
        begin
            state_reg     <= IDLE;
            ld_cnt_reg    <= '0;
            row_reg       <= '0;
            col_reg       <= '0;
            seen_last_reg <= 1'b0;
            issue_valid_o <= 1'b0;
            issue_last_o  <= 1'b0;
        end
        else
        begin
            state_reg     <= state_next;
            ld_cnt_reg    <= ld_cnt_next;
            row_reg       <= row_next;
            col_reg       <= col_next;
            seen_last_reg <= seen_last_next;
            issue_valid_o <= (state_reg == COMPUTE);  // Lines up with buffer read data
            issue_last_o  <= (state_reg == COMPUTE) && last_elem;
        end
    end

endmodule

/* hdl/mm_accel_top.sv */
// Q8.8 matrix multiply C = A * W^T, A and W streamed as rows of four elements
// Jobs are framed by row counts only; C leaves one element per beat with tlast on the last
module mm_accel_top #(
    parameter int I_ROWS = 8,
    parameter int W_ROWS = 6
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic [mm_pkg::ROW_WIDTH-1:0] s_axis_i_tdata,
    input  logic                         s_axis_i_tvalid,
    output logic                         s_axis_i_tready,
    input  logic [mm_pkg::ROW_WIDTH-1:0] s_axis_w_tdata,
    input  logic                         s_axis_w_tvalid,
    output logic                         s_axis_w_tready,
    output logic [mm_pkg::ELEM_WIDTH-1:0] m_axis_tdata,
    output logic                         m_axis_tvalid,
    output logic                         m_axis_tlast,
    input  logic                         m_axis_tready
);
    localparam int LD_AW     = $clog2(mm_pkg::max_rows(I_ROWS, W_ROWS));
    localparam int A_AW      = $clog2(I_ROWS);
    localparam int W_AW      = $clog2(W_ROWS);
    localparam int I_DEPTH   = 2 * I_ROWS;                    // Room for the next job
    localparam int W_DEPTH   = 2 * W_ROWS;
    localparam int OUT_DEPTH = 64;                            // >= I_ROWS * W_ROWS
    localparam int OUT_WIDTH = mm_pkg::ELEM_WIDTH + 1;        // Element plus last

    logic              a_wr_en;
    logic              w_wr_en;
    logic [LD_AW-1:0]  wr_addr;
    logic [A_AW-1:0]   a_rd_addr;
    logic [W_AW-1:0]   w_rd_addr;
    mm_pkg::row_word_t a_row;
    mm_pkg::row_word_t w_row;
    logic              issue_valid;
    logic              issue_last;
    mm_pkg::elem_t     res_data;
    logic              res_valid;
    logic              res_last;

    fifo_rd_if #(.DEPTH(I_DEPTH))   a_rd_if   (.aclk_i(aclk), .aresetn_i(aresetn));
    fifo_rd_if #(.DEPTH(W_DEPTH))   w_rd_if   (.aclk_i(aclk), .aresetn_i(aresetn));
    fifo_rd_if #(.DEPTH(OUT_DEPTH)) out_rd_if (.aclk_i(aclk), .aresetn_i(aresetn));

    stream_fifo #(.DATA_WIDTH(mm_pkg::ROW_WIDTH), .DEPTH(I_DEPTH)) u_a_fifo (
        .aclk_i(aclk), .aresetn_i(aresetn),
        .s_tdata_i(s_axis_i_tdata), .s_tvalid_i(s_axis_i_tvalid), .s_tready_o(s_axis_i_tready),
        .rd(a_rd_if.fifo_side)
    );

    stream_fifo #(.DATA_WIDTH(mm_pkg::ROW_WIDTH), .DEPTH(W_DEPTH)) u_w_fifo (
        .aclk_i(aclk), .aresetn_i(aresetn),
        .s_tdata_i(s_axis_w_tdata), .s_tvalid_i(s_axis_w_tvalid), .s_tready_o(s_axis_w_tready),
        .rd(w_rd_if.fifo_side)
    );

    // Load address is as wide as the longer matrix needs
    operand_buffer #(.ROWS(I_ROWS)) u_a_buf (
        .aclk_i(aclk), .wr_en_i(a_wr_en), .wr_addr_i(wr_addr[A_AW-1:0]),
        .wr_row_i(a_rd_if.rd_data), .rd_addr_i(a_rd_addr), .rd_row_o(a_row)
    );

    operand_buffer #(.ROWS(W_ROWS)) u_w_buf (
        .aclk_i(aclk), .wr_en_i(w_wr_en), .wr_addr_i(wr_addr[W_AW-1:0]),
        .wr_row_i(w_rd_if.rd_data), .rd_addr_i(w_rd_addr), .rd_row_o(w_row)
    );

    mm_controller #(.I_ROWS(I_ROWS), .W_ROWS(W_ROWS)) u_ctrl (
        .aclk_i(aclk), .aresetn_i(aresetn),
        .a_rd(a_rd_if.reader_side), .w_rd(w_rd_if.reader_side),
        .out_empty_i(out_rd_if.empty),
        .a_wr_en_o(a_wr_en), .w_wr_en_o(w_wr_en), .wr_addr_o(wr_addr),
        .a_rd_addr_o(a_rd_addr), .w_rd_addr_o(w_rd_addr),
        .issue_valid_o(issue_valid), .issue_last_o(issue_last),
        .res_last_i(res_last)
    );

    dot_product_unit u_dot (
        .aclk_i(aclk), .aresetn_i(aresetn),
        .valid_i(issue_valid), .last_i(issue_last),
        .a_row_i(a_row), .w_row_i(w_row),
        .result_o(res_data), .valid_o(res_valid), .last_o(res_last)
    );

    // Depth covers a whole job, so the write side never sees back-pressure
    stream_fifo #(.DATA_WIDTH(OUT_WIDTH), .DEPTH(OUT_DEPTH)) u_out_fifo (
        .aclk_i(aclk), .aresetn_i(aresetn),
        .s_tdata_i({res_last, res_data}), .s_tvalid_i(res_valid), .s_tready_o(),
        .rd(out_rd_if.fifo_side)
    );

    assign m_axis_tvalid   = !out_rd_if.empty;
    assign out_rd_if.rd_en = m_axis_tvalid && m_axis_tready;          // Beat taken
    assign m_axis_tdata    = out_rd_if.rd_data.flat[mm_pkg::ELEM_WIDTH-1:0];
    assign m_axis_tlast    = out_rd_if.rd_data.flat[mm_pkg::ELEM_WIDTH];

endmodule

/* test/tb_clock.sv */
// Free-running clock and synchronous active-low reset for the testbench
// Reset is released on a rising edge and is first seen high at the following one
module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic aclk,
    output logic aresetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    initial
    begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);  // Low for RESET_CYCLES edges
        aresetn <= 1'b1;
    end

endmodule

/* test/mm_ref.svh */
// Reference arithmetic and stimulus helpers, included inside the testbench module
// Element k of a row sits at bits [16*k+15:16*k]; results are Q8.8 with saturation
`ifndef MM_REF_SVH
`define MM_REF_SVH

// 32-bit xorshift, state never zero
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [63:0] pack_row(input logic [15:0] e0, e1, e2, e3);
    return {e3, e2, e1, e0};                        // Element 0 in the low half-word
endfunction

// One element of C from a row of A and a row of W
function automatic logic [15:0] ref_dot(input logic [63:0] a_row, input logic [63:0] w_row);
    longint sum;
    longint scaled;
    sum = 0;
    for (int k = 0; k < 4; k++)
    begin
        sum += longint'($signed(a_row[16*k +: 16])) * longint'($signed(w_row[16*k +: 16]));
    end
    scaled = sum >>> 8;                             // Drop Q8.8 fraction, rounds toward -inf
    if (scaled > 32767)
    begin
        return 16'h7fff;                            // Clamp high
    end
    else if (scaled < -32768)
    begin
        return 16'h8000;                            // Clamp low
    end
    return scaled[15:0];
endfunction

`endif

/* test/tb_mm_accel.sv */
// Runs reset, random, saturating, split-arrival, back-pressure and back-to-back jobs
// Expected C is queued per job from ref_dot and checked beat by beat by the monitor
module tb_mm_accel;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int I_ROWS = 8;
    localparam int W_ROWS = 6;
    localparam int LIMIT  = 2000;                   // Cycles allowed for any one wait

    logic        aclk;
    logic        aresetn;
    logic [63:0] s_axis_i_tdata;
    logic        s_axis_i_tvalid;
    logic        s_axis_i_tready;
    logic [63:0] s_axis_w_tdata;
    logic        s_axis_w_tvalid;
    logic        s_axis_w_tready;
    logic [15:0] m_axis_tdata;
    logic        m_axis_tvalid;
    logic        m_axis_tlast;
    logic        m_axis_tready;

    logic [63:0] a_rows [I_ROWS];                   // Current job, A
    logic [63:0] w_rows [W_ROWS];                   // Current job, W
    logic [16:0] exp_q [$];                         // {last, element} still to come
    string       test_name;
    logic [31:0] data_rng;
    logic [31:0] ready_rng;
    logic        random_ready;

    `include "mm_ref.svh"

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clock (.aclk(aclk), .aresetn(aresetn));

    mm_accel_top #(.I_ROWS(I_ROWS), .W_ROWS(W_ROWS)) u_dut (
        .aclk(aclk), .aresetn(aresetn),
        .s_axis_i_tdata(s_axis_i_tdata), .s_axis_i_tvalid(s_axis_i_tvalid),
        .s_axis_i_tready(s_axis_i_tready),
        .s_axis_w_tdata(s_axis_w_tdata), .s_axis_w_tvalid(s_axis_w_tvalid),
        .s_axis_w_tready(s_axis_w_tready),
        .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tlast(m_axis_tlast), .m_axis_tready(m_axis_tready)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic logic [15:0] small_elem();
        data_rng = xorshift32(data_rng);
        return {{5{data_rng[10]}}, data_rng[10:0]}; // Within +-4.0, sums rarely clamp
    endfunction

    task automatic make_random_job();
        for (int i = 0; i < I_ROWS; i++)
        begin
            a_rows[i] = pack_row(small_elem(), small_elem(), small_elem(), small_elem());
        end
        for (int j = 0; j < W_ROWS; j++)
        begin
            w_rows[j] = pack_row(small_elem(), small_elem(), small_elem(), small_elem());
        end
    endtask

    // +-127.0 rows against large and small weights
    task automatic make_saturation_job();
        for (int i = 0; i < I_ROWS; i++)
        begin
            a_rows[i] = (i % 2 == 0) ? {4{16'h7f00}} : {4{16'h8100}};
        end
        for (int j = 0; j < W_ROWS; j++)
        begin
            w_rows[j] = (j < 3) ? {4{16'h7f00}} :
                pack_row(small_elem(), small_elem(), small_elem(), small_elem());
        end
    endtask

    task automatic queue_expected();
        for (int i = 0; i < I_ROWS; i++)
        begin
            for (int j = 0; j < W_ROWS; j++)
            begin
                exp_q.push_back({(i == I_ROWS - 1) && (j == W_ROWS - 1),
                                 ref_dot(a_rows[i], w_rows[j])});
            end
        end
    endtask

    // Streams rows first..first+count-1 of A or W, called on a rising edge
    task automatic send_rows(input bit w_side, input int first, input int count);
        int waited;
        for (int r = first; r < first + count; r++)
        begin
            if (w_side)
            begin
                s_axis_w_tdata  <= w_rows[r];
                s_axis_w_tvalid <= 1'b1;
            end
            else
            begin
                s_axis_i_tdata  <= a_rows[r];
                s_axis_i_tvalid <= 1'b1;
            end
            waited = 0;
            @(posedge aclk);
            while (!(w_side ? s_axis_w_tready : s_axis_i_tready))
            begin
                waited++;
                assert (waited < LIMIT)
                else abort_run($sformatf("Timed out waiting for tready, %s stream",
                                         w_side ? "W" : "A"));
                @(posedge aclk);
            end
        end
        if (w_side)
        begin
            s_axis_w_tvalid <= 1'b0;
        end
        else
        begin
            s_axis_i_tvalid <= 1'b0;
        end
    endtask

    // Monitor pops on the rising edge, so the queue is read on the falling one
    task automatic wait_drained();
        int waited;
        waited = 0;
        do
        begin
            @(negedge aclk);
            waited++;
            assert (waited < LIMIT)
            else abort_run($sformatf("Timed out waiting for the results of %s", test_name));
        end
        while (exp_q.size() != 0);
        @(posedge aclk);
    endtask

    task automatic run_job();
        queue_expected();
        fork
            send_rows(1'b0, 0, I_ROWS);
            send_rows(1'b1, 0, W_ROWS);
        join
        wait_drained();
    endtask

    always @(posedge aclk)
    begin
        logic [16:0] exp_beat;
        if (aresetn && m_axis_tvalid && m_axis_tready)  // Beat taken at this edge
        begin
            assert (exp_q.size() != 0)
            else abort_run($sformatf("Output beat in %s with no result expected", test_name));
            exp_beat = exp_q.pop_front();
            assert ({m_axis_tlast, m_axis_tdata} == exp_beat)
            else abort_run($sformatf("ERROR %s: expected %h last %b, actual %h last %b",
                                     test_name, exp_beat[15:0], exp_beat[16],
                                     m_axis_tdata, m_axis_tlast));
        end
    end

    initial
    begin
        m_axis_tready = 1'b1;
        ready_rng     = 32'd28;
        forever
        begin
            @(posedge aclk);
            ready_rng = xorshift32(ready_rng);
            m_axis_tready <= random_ready ? ready_rng[0] : 1'b1;
        end
    end

    initial
    begin
        int waited;
        s_axis_i_tdata  = '0;
        s_axis_i_tvalid = 1'b0;
        s_axis_w_tdata  = '0;
        s_axis_w_tvalid = 1'b0;
        random_ready    = 1'b0;
        data_rng        = 32'd28;
        test_name       = "reset_state";
        waited          = 0;
        while (aresetn !== 1'b1)
        begin
            @(posedge aclk);
            waited++;
            assert (waited < LIMIT) else abort_run("Timed out waiting for reset release");
        end
        assert (!m_axis_tvalid && s_axis_i_tready && s_axis_w_tready)
        else abort_run("After reset tvalid is not low or a tready is not high");

        test_name = "single_job";
        make_random_job();
        run_job();

        test_name = "saturation";
        make_saturation_job();
        run_job();

        test_name = "start_condition";
        make_random_job();
        queue_expected();
        fork
            send_rows(1'b0, 0, I_ROWS);
            send_rows(1'b1, 0, 3);                  // W held back after 3 rows
        join
        for (int c = 0; c < 100; c++)
        begin
            @(posedge aclk);
            assert (!m_axis_tvalid)
            else abort_run("Output appeared before the weight matrix was complete");
        end
        send_rows(1'b1, 3, W_ROWS - 3);
        wait_drained();

        test_name = "back_pressure";
        random_ready <= 1'b1;
        make_random_job();
        run_job();
        random_ready <= 1'b0;

        test_name = "back_to_back";
        make_random_job();
        queue_expected();
        fork
            send_rows(1'b0, 0, I_ROWS);
            send_rows(1'b1, 0, W_ROWS);
        join
        make_random_job();                          // Streams while the first job computes
        run_job();

        repeat (20) @(posedge aclk);                // Stray beats would reach the monitor
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* src.f */
+incdir+test
hdl/mm_pkg.sv
hdl/fifo_rd_if.sv
hdl/stream_fifo.sv
hdl/operand_buffer.sv
hdl/dot_product_unit.sv
hdl/mm_controller.sv
hdl/mm_accel_top.sv
test/tb_clock.sv
test/tb_mm_accel.sv

/* Bender.yml */
package:
  name: mm_accel

sources:
  - hdl/mm_pkg.sv
  - hdl/fifo_rd_if.sv
  - hdl/stream_fifo.sv
  - hdl/operand_buffer.sv
  - hdl/dot_product_unit.sv
  - hdl/mm_controller.sv
  - hdl/mm_accel_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_clock.sv
      - test/tb_mm_accel.sv
